// ==== rtl/data_ram.sv ====
`timescale 1ns/10ps

module data_ram
    import pipe_pkg::*;
    import mem_pkg::*;
#(
    parameter int ADDR_BITS = 8
)
(
    input  logic     clk,
    input  logic     rst,
    input  wait_t    wait_states,
    mem_bus_if.slave bus
);

    localparam int WORDS = 2 ** ADDR_BITS;

    word_t                 mem [WORDS];
    logic [WORDS-1:0]      word_valid;  // Word has been written since reset
    logic [ADDR_BITS-1:0]  word_idx;
    logic                  req;
    logic                  busy;
    wait_t                 wait_cnt;

    assign word_idx = bus.addr[ADDR_BITS+1:2];  // Byte offset ignored
    assign req      = bus.re || bus.we;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            busy       <= 1'b0;
            wait_cnt   <= '0;
            bus.done   <= 1'b0;
            word_valid <= '0;
        end
        else
        begin
            bus.done <= 1'b0;
            if (bus.we)
                word_valid[word_idx] <= 1'b1;
            if (req)
            begin
                if (wait_states == '0)
                    bus.done <= 1'b1;  // No wait states
                else
                begin
                    busy     <= 1'b1;
                    wait_cnt <= wait_states - 4'd1;
                end
            end
            else if (busy)
            begin
                if (wait_cnt == '0)
                begin
                    busy     <= 1'b0;
                    bus.done <= 1'b1;
                end
                else
                    wait_cnt <= wait_cnt - 4'd1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (bus.we)
            mem[word_idx] <= bus.wdata;
        if (bus.re)
            bus.rdata <= word_valid[word_idx] ? mem[word_idx] : '0;  // Held until next read
    end

endmodule

// ==== rtl/mem_bus_if.sv ====
`timescale 1ns/10ps

interface mem_bus_if
    import pipe_pkg::*;
();

    word_t addr;   // Byte address
    word_t wdata;
    logic  we;     // Write request pulse
    logic  re;     // Read request pulse
    word_t rdata;  // Valid while done is high
    logic  done;   // Completion pulse

    modport master (
        output addr,
        output wdata,
        output we,
        output re,
        input  rdata,
        input  done
    );

    modport slave (
        input  addr,
        input  wdata,
        input  we,
        input  re,
        output rdata,
        output done
    );

    // Event counters only watch the request pulses
    modport monitor (
        input we,
        input re
    );

endinterface

// ==== rtl/mem_pkg.sv ====
package mem_pkg;

    typedef logic [3:0]  wait_t;      // Extra RAM cycles before done
    typedef logic [15:0] count_t;     // Load or store event count, wraps
    typedef logic [1:0]  cfg_addr_t;  // Config register select

    // Config register map
    localparam cfg_addr_t CFG_WAIT   = 2'd0;  // Wait states, read and write
    localparam cfg_addr_t CFG_LOADS  = 2'd1;  // Load count, read only
    localparam cfg_addr_t CFG_STORES = 2'd2;  // Store count, read only

endpackage

// ==== rtl/mem_stage.sv ====
`timescale 1ns/10ps

module mem_stage
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      stall,
    input  logic      instr_valid,
    input  word_t     alu_result,
    input  word_t     store_data,
    input  word_t     branch_target,
    input  logic      mem_read,
    input  logic      mem_write,
    input  logic      mem_to_reg,
    input  logic      reg_write,
    input  logic      pc_src,
    input  reg_idx_t  reg_dest,
    mem_bus_if.master bus,
    output logic      stall_pipeline,
    output logic      out_valid,
    output word_t     out_alu_result,
    output word_t     out_load_data,
    output word_t     out_branch_target,
    output logic      out_mem_to_reg,
    output logic      out_reg_write,
    output logic      out_pc_src,
    output reg_idx_t  out_reg_dest
);

    logic  accept;
    logic  is_mem;
    logic  mem_finish;
    word_t addr_q;
    word_t wdata_q;

    assign accept     = instr_valid && !stall && !stall_pipeline;
    assign is_mem     = mem_read || mem_write;
    assign mem_finish = stall_pipeline && bus.done;  // Outstanding access completes

    assign bus.addr       = addr_q;
    assign bus.wdata      = wdata_q;
    assign out_alu_result = addr_q;  // ALU result doubles as the address

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            stall_pipeline <= 1'b0;
            bus.re         <= 1'b0;
            bus.we         <= 1'b0;
            out_valid      <= 1'b0;
        end
        else
        begin
            bus.re    <= 1'b0;  // Requests last one cycle
            bus.we    <= 1'b0;
            out_valid <= 1'b0;
            if (accept)
            begin
                if (is_mem)
                begin
                    stall_pipeline <= 1'b1;  // Hold upstream until done
                    bus.re         <= mem_read;
                    bus.we         <= mem_write;
                end
                else
                    out_valid <= 1'b1;  // Nothing to wait for
            end
            else if (mem_finish)
            begin
                stall_pipeline <= 1'b0;
                out_valid      <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            addr_q            <= alu_result;
            wdata_q           <= store_data;
            out_branch_target <= branch_target;
            out_mem_to_reg    <= mem_to_reg;
            out_reg_write     <= reg_write;
            out_pc_src        <= pc_src;
            out_reg_dest      <= reg_dest;
        end
        if (mem_finish)
            out_load_data <= bus.rdata;  // Capture with done
    end

endmodule

// ==== rtl/mem_subsystem_top.sv ====
`timescale 1ns/10ps

module mem_subsystem_top
    import pipe_pkg::*;
    import mem_pkg::*;
#(
    parameter int ADDR_BITS  = 8,
    parameter int RESET_WAIT = 2
)
(
    input  logic      clk,
    input  logic      rst,
    input  logic      instr_valid,
    input  logic      stall,
    input  word_t     alu_result,
    input  word_t     store_data,
    input  word_t     branch_target,
    input  logic      mem_read,
    input  logic      mem_write,
    input  logic      mem_to_reg,
    input  logic      reg_write,
    input  logic      pc_src,
    input  reg_idx_t  reg_dest,
    input  logic      cfg_we,
    input  cfg_addr_t cfg_addr,
    input  count_t    cfg_wdata,
    output logic      stall_pipeline,
    output logic      wb_reg_we,
    output reg_idx_t  wb_reg_dest,
    output word_t     wb_reg_data,
    output logic      branch_taken,
    output word_t     branch_out_target,
    output count_t    cfg_rdata
);

    mem_bus_if bus_if ();

    wait_t    wait_states;
    logic     ms_valid;
    word_t    ms_alu_result;
    word_t    ms_load_data;
    word_t    ms_branch_target;
    logic     ms_mem_to_reg;
    logic     ms_reg_write;
    logic     ms_pc_src;
    reg_idx_t ms_reg_dest;

    mem_stage mem_stage_i (
        .clk               (clk),
        .rst               (rst),
        .stall             (stall),
        .instr_valid       (instr_valid),
        .alu_result        (alu_result),
        .store_data        (store_data),
        .branch_target     (branch_target),
        .mem_read          (mem_read),
        .mem_write         (mem_write),
        .mem_to_reg        (mem_to_reg),
        .reg_write         (reg_write),
        .pc_src            (pc_src),
        .reg_dest          (reg_dest),
        .bus               (bus_if.master),
        .stall_pipeline    (stall_pipeline),
        .out_valid         (ms_valid),
        .out_alu_result    (ms_alu_result),
        .out_load_data     (ms_load_data),
        .out_branch_target (ms_branch_target),
        .out_mem_to_reg    (ms_mem_to_reg),
        .out_reg_write     (ms_reg_write),
        .out_pc_src        (ms_pc_src),
        .out_reg_dest      (ms_reg_dest)
    );

    data_ram #(
        .ADDR_BITS (ADDR_BITS)
    ) data_ram_i (
        .clk         (clk),
        .rst         (rst),
        .wait_states (wait_states),
        .bus         (bus_if.slave)
    );

    ram_timing_regs #(
        .RESET_WAIT (RESET_WAIT)
    ) ram_timing_regs_i (
        .clk         (clk),
        .rst         (rst),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .wait_states (wait_states),
        .bus         (bus_if.monitor)
    );

    writeback_stage writeback_stage_i (
        .clk               (clk),
        .rst               (rst),
        .in_valid          (ms_valid),
        .alu_result        (ms_alu_result),
        .load_data         (ms_load_data),
        .branch_target     (ms_branch_target),
        .mem_to_reg        (ms_mem_to_reg),
        .reg_write         (ms_reg_write),
        .pc_src            (ms_pc_src),
        .reg_dest          (ms_reg_dest),
        .wb_reg_we         (wb_reg_we),
        .branch_taken      (branch_taken),
        .wb_reg_dest       (wb_reg_dest),
        .wb_reg_data       (wb_reg_data),
        .branch_out_target (branch_out_target)
    );

endmodule

// ==== rtl/pipe_pkg.sv ====
package pipe_pkg;

    // Data word, byte address or branch target
    typedef logic [31:0] word_t;

    // Register-file destination index
    typedef logic [4:0] reg_idx_t;

endpackage

// ==== rtl/ram_timing_regs.sv ====
`timescale 1ns/10ps

module ram_timing_regs
    import mem_pkg::*;
#(
    parameter int RESET_WAIT = 2
)
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cfg_we,
    input  cfg_addr_t  cfg_addr,
    input  count_t     cfg_wdata,
    output count_t     cfg_rdata,
    output wait_t      wait_states,
    mem_bus_if.monitor bus
);

    wait_t  wait_q;
    count_t load_cnt;
    count_t store_cnt;

    assign wait_states = wait_q;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wait_q    <= wait_t'(RESET_WAIT);
            load_cnt  <= '0;
            store_cnt <= '0;
        end
        else
        begin
            if (cfg_we && cfg_addr == CFG_WAIT)
                wait_q <= cfg_wdata[3:0];
            if (bus.re)
                load_cnt <= load_cnt + 16'd1;  // Wraps at 16 bits
            if (bus.we)
                store_cnt <= store_cnt + 16'd1;
        end
    end

    always_comb
    begin
        case (cfg_addr)
            CFG_WAIT:   cfg_rdata = count_t'(wait_q);
            CFG_LOADS:  cfg_rdata = load_cnt;
            CFG_STORES: cfg_rdata = store_cnt;
            default:    cfg_rdata = '0;
        endcase
    end

endmodule

// ==== rtl/writeback_stage.sv ====
`timescale 1ns/10ps

module writeback_stage
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  word_t    alu_result,
    input  word_t    load_data,
    input  word_t    branch_target,
    input  logic     mem_to_reg,
    input  logic     reg_write,
    input  logic     pc_src,
    input  reg_idx_t reg_dest,
    output logic     wb_reg_we,
    output logic     branch_taken,
    output reg_idx_t wb_reg_dest,
    output word_t    wb_reg_data,
    output word_t    branch_out_target
);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wb_reg_we    <= 1'b0;
            branch_taken <= 1'b0;
        end
        else
        begin
            wb_reg_we    <= in_valid && reg_write;
            branch_taken <= in_valid && pc_src;  // One-cycle redirect
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            wb_reg_dest       <= reg_dest;
            wb_reg_data       <= mem_to_reg ? load_data : alu_result;
            branch_out_target <= branch_target;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module mem_subsystem_tb -o sim_mem_subsystem

output=$(./obj_dir/sim_mem_subsystem)
echo "$output"

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
echo "Simulation did not pass"
exit 1

// ==== verification/mem_subsystem_tb.sv ====
`timescale 1ns/10ps

module mem_subsystem_tb
    import pipe_pkg::*;
    import mem_pkg::*;
();

    localparam int ADDR_BITS  = 8;
    localparam int RESET_WAIT = 2;
    localparam int WORDS      = 2 ** ADDR_BITS;

    logic      clk;
    logic      rst;
    logic      instr_valid;
    logic      stall;
    word_t     alu_result;
    word_t     store_data;
    word_t     branch_target;
    logic      mem_read;
    logic      mem_write;
    logic      mem_to_reg;
    logic      reg_write;
    logic      pc_src;
    reg_idx_t  reg_dest;
    logic      cfg_we;
    cfg_addr_t cfg_addr;
    count_t    cfg_wdata;
    logic      stall_pipeline;
    logic      wb_reg_we;
    reg_idx_t  wb_reg_dest;
    word_t     wb_reg_data;
    logic      branch_taken;
    word_t     branch_out_target;
    count_t    cfg_rdata;

    logic [31:0] lfsr;
    int          mismatch_count;
    int          fail_count;

    // Reference model state
    word_t    model_mem [WORDS];
    logic     model_written [WORDS];
    wait_t    model_wait;
    count_t   model_loads;
    count_t   model_stores;
    reg_idx_t exp_dest_q [$];
    word_t    exp_data_q [$];
    word_t    exp_target_q [$];

    mem_subsystem_top #(
        .ADDR_BITS  (ADDR_BITS),
        .RESET_WAIT (RESET_WAIT)
    ) mem_subsystem_top_i (
        .clk               (clk),
        .rst               (rst),
        .instr_valid       (instr_valid),
        .stall             (stall),
        .alu_result        (alu_result),
        .store_data        (store_data),
        .branch_target     (branch_target),
        .mem_read          (mem_read),
        .mem_write         (mem_write),
        .mem_to_reg        (mem_to_reg),
        .reg_write         (reg_write),
        .pc_src            (pc_src),
        .reg_dest          (reg_dest),
        .cfg_we            (cfg_we),
        .cfg_addr          (cfg_addr),
        .cfg_wdata         (cfg_wdata),
        .stall_pipeline    (stall_pipeline),
        .wb_reg_we         (wb_reg_we),
        .wb_reg_dest       (wb_reg_dest),
        .wb_reg_data       (wb_reg_data),
        .branch_taken      (branch_taken),
        .branch_out_target (branch_out_target),
        .cfg_rdata         (cfg_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            if (lfsr[0])
                lfsr = (lfsr >> 1) ^ 32'h8020_0003;
            else
                lfsr = lfsr >> 1;
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act)
        begin
            mismatch_count++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_dest(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (exp !== act)
        begin
            mismatch_count++;
            $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (exp !== act)
        begin
            mismatch_count++;
            $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic drive_idle;
        instr_valid   = 1'b0;
        stall         = 1'b0;
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        mem_to_reg    = 1'b0;
        reg_write     = 1'b0;
        pc_src        = 1'b0;
        alu_result    = '0;
        store_data    = '0;
        branch_target = '0;
        reg_dest      = '0;
    endtask

    // Combinational readback sampled mid low phase
    task automatic read_cfg(input string name, input cfg_addr_t addr, input count_t exp);
        cfg_addr = addr;
        #5;
        check_count(name, exp, cfg_rdata);
        @(negedge clk);
    endtask

    task automatic write_wait_states;
        count_t wdata;
        wdata     = count_t'(rand_bits(16));
        cfg_we    = 1'b1;
        cfg_addr  = cfg_addr_t'(0);
        cfg_wdata = wdata;
        @(negedge clk);
        cfg_we     = 1'b0;
        model_wait = wdata[3:0];  // Upper bits ignored
        read_cfg("wait states readback", cfg_addr_t'(0), count_t'(model_wait));
    endtask

    // kind 0 is a load, 1 a store, anything else a non-memory op
    task automatic issue_instr(input logic [1:0] kind);
        logic                 is_load;
        logic                 is_store;
        logic [ADDR_BITS-1:0] idx;
        word_t                addr;
        word_t                sdata;
        word_t                btgt;
        word_t                exp_data;
        reg_idx_t             dest;
        logic                 rw;
        logic                 pcs;
        logic                 poke;
        count_t               exp_stall;
        int                   cycles;
        int                   guard;
        is_load  = (kind == 2'd0);
        is_store = (kind == 2'd1);
        if (is_load || is_store)
            addr = {26'd0, 4'(rand_bits(4)), 2'(rand_bits(2))};  // 16-word window
        else
            addr = rand_bits(32);
        sdata = rand_bits(32);
        btgt  = rand_bits(32);
        dest  = reg_idx_t'(rand_bits(5));
        rw    = 1'(rand_bits(1)) && !is_store;
        pcs   = 1'(rand_bits(1));
        poke  = 1'(rand_bits(1));
        idx   = addr[ADDR_BITS+1:2];
        exp_data = addr;
        if (is_load)
        begin
            exp_data    = model_written[idx] ? model_mem[idx] : '0;
            model_loads = model_loads + 16'd1;
        end
        if (is_store)
        begin
            model_mem[idx]     = sdata;
            model_written[idx] = 1'b1;
            model_stores       = model_stores + 16'd1;
        end
        if (rw)
        begin
            exp_dest_q.push_back(dest);
            exp_data_q.push_back(exp_data);
        end
        if (pcs)
            exp_target_q.push_back(btgt);
        instr_valid   = 1'b1;
        alu_result    = addr;
        store_data    = sdata;
        branch_target = btgt;
        mem_read      = is_load;
        mem_write     = is_store;
        mem_to_reg    = is_load;
        reg_write     = rw;
        pc_src        = pcs;
        reg_dest      = dest;
        @(negedge clk);  // Accepting edge has passed
        instr_valid = 1'b0;
        if (is_load || is_store)
        begin
            exp_stall = count_t'(model_wait) + 16'd2;
            cycles    = 0;
            guard     = 0;
            while (stall_pipeline && guard < 64)
            begin
                cycles++;
                guard++;
                instr_valid = poke;  // Must be ignored while stalled
                reg_write   = 1'b1;
                pc_src      = 1'b1;
                @(negedge clk);
            end
            instr_valid = 1'b0;
            if (guard >= 64)
            begin
                fail_count++;
                $display("Timeout: stall_pipeline never cleared after a memory access");
            end
            check_count("stall cycles", exp_stall, count_t'(cycles));
        end
        else if (stall_pipeline)
        begin
            fail_count++;
            $display("stall_pipeline rose for a non-memory instruction");
        end
        drive_idle();
        @(negedge clk);
    endtask

    task automatic strobe_while_stalled;
        stall       = 1'b1;
        instr_valid = 1'b1;
        alu_result  = rand_bits(32);
        mem_read    = 1'(rand_bits(1));
        mem_write   = !mem_read;
        reg_write   = 1'b1;
        pc_src      = 1'b1;
        repeat (2) @(negedge clk);
        drive_idle();
        @(negedge clk);
    endtask

    task automatic drain_queues;
        int guard;
        guard = 0;
        while ((exp_dest_q.size() != 0 || exp_target_q.size() != 0) && guard < 40)
        begin
            guard++;
            @(negedge clk);
        end
        if (guard >= 40)
        begin
            fail_count++;
            $display("Timeout: expected writebacks or branches never arrived");
        end
        repeat (4) @(negedge clk);  // Catch late spurious writebacks
    endtask

    // Writeback and branch monitor
    always @(negedge clk)
    begin
        if (!rst && wb_reg_we)
        begin
            if (exp_dest_q.size() == 0)
            begin
                fail_count++;
                $display("Unexpected register write to x%0d", wb_reg_dest);
            end
            else
            begin
                check_dest("writeback dest", exp_dest_q.pop_front(), wb_reg_dest);
                check_word("writeback data", exp_data_q.pop_front(), wb_reg_data);
            end
        end
        if (!rst && branch_taken)
        begin
            if (exp_target_q.size() == 0)
            begin
                fail_count++;
                $display("Unexpected branch redirect to %h", branch_out_target);
            end
            else
                check_word("branch target", exp_target_q.pop_front(), branch_out_target);
        end
    end

    initial
    begin
        int round;
        int n;
        lfsr           = 32'hc7e0_cd8a;
        mismatch_count = 0;
        fail_count     = 0;
        model_wait     = wait_t'(RESET_WAIT);
        model_loads    = '0;
        model_stores   = '0;
        for (n = 0; n < WORDS; n++)
            model_written[n] = 1'b0;
        drive_idle();
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        rst       = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        read_cfg("reset wait states", cfg_addr_t'(0), count_t'(RESET_WAIT));
        for (round = 0; round < 8; round++)
        begin
            write_wait_states();
            for (n = 0; n < 12; n++)
                issue_instr(2'(rand_bits(2)));
            strobe_while_stalled();
            read_cfg("load count", cfg_addr_t'(1), model_loads);
            read_cfg("store count", cfg_addr_t'(2), model_stores);
            read_cfg("unused register", cfg_addr_t'(3), '0);
        end
        drain_queues();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/pipe_pkg.sv
rtl/mem_pkg.sv
rtl/mem_bus_if.sv
rtl/mem_stage.sv
rtl/data_ram.sv
rtl/ram_timing_regs.sv
rtl/writeback_stage.sv
rtl/mem_subsystem_top.sv
verification/mem_subsystem_tb.sv
